//--- hw/pce_audio_pkg.sv
package pce_audio_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// One voice or output sample
	localparam int SAMPLE_W = 16;

	// Mixing sum, two bits of headroom over a sample
	localparam int MIX_W = 18;

	// Input to output delay in clk_sys cycles
	localparam int PIPE_LATENCY = 4;

	//////////////////////////////////////////////////
	// Sample types
	//////////////////////////////////////////////////

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [MIX_W-1:0]    mix_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_sample_t;

	typedef struct packed {
		mix_t left;
		mix_t right;
	} stereo_mix_t;

	//////////////////////////////////////////////////
	// Configuration
	//////////////////////////////////////////////////

	// 0 none, 1 gives 2x, 2 gives 4x
	// Bit 0 picks the middle shift, any set bit adds the extra halving
	typedef logic [1:0] boost_t;

	// 0 bypass; nonzero compresses, bit 1 selects the heavy curve
	typedef logic [1:0] comp_mode_t;

	//////////////////////////////////////////////////
	// Attenuation
	//////////////////////////////////////////////////

	// Third term of the reduction sum
	localparam int PSG_TAIL_SHIFT   = 4;
	localparam int ADPCM_TAIL_SHIFT = 3;

	//////////////////////////////////////////////////
	// Compressor curves
	//////////////////////////////////////////////////

	// Below X the slope is A, above it 1/F with offset B
	// B is X times A so both slopes meet at the knee
	localparam logic [SAMPLE_W-1:0] COMP_LIGHT_F = 16'd4;
	localparam logic [SAMPLE_W-1:0] COMP_LIGHT_A = 16'd2;
	localparam logic [SAMPLE_W-1:0] COMP_LIGHT_X = 16'd14043;
	localparam logic [SAMPLE_W-1:0] COMP_LIGHT_B = 16'd28086;

	localparam logic [SAMPLE_W-1:0] COMP_HEAVY_F = 16'd8;
	localparam logic [SAMPLE_W-1:0] COMP_HEAVY_A = 16'd4;
	localparam logic [SAMPLE_W-1:0] COMP_HEAVY_X = 16'd7399;
	localparam logic [SAMPLE_W-1:0] COMP_HEAVY_B = 16'd29596;

endpackage

//--- hw/voice_attenuator.sv
`timescale 1ns/1ps

module voice_attenuator
	import pce_audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,

	input  boost_t         boost,
	input  stereo_sample_t psg,
	input  sample_t        adpcm,
	input  stereo_sample_t cdda,

	output stereo_sample_t psg_red,
	output sample_t        adpcm_red,
	output stereo_sample_t cdda_q
);

	//////////////////////////////////////////////////
	// Three-term reduction
	//////////////////////////////////////////////////

	// x/2 + x/2 or x/4 + x>>tail, wrapped to 16 bits
	// Any boost halves the result once more
	function automatic sample_t reduce(
		input sample_t x,
		input int      tail,
		input boost_t  b
	);
		sample_t half;
		sample_t mid;
		sample_t tail_term;
		sample_t sum;

		half      = x >>> 1;
		mid       = b[0] ? (x >>> 1) : (x >>> 2);
		tail_term = x >>> tail;
		sum       = half + mid + tail_term;

		if (b != 2'd0) begin
			sum = sum >>> 1;
		end

		return sum;
	endfunction

	// Combinational results ahead of the stage register
	sample_t psg_l_next;
	sample_t psg_r_next;
	sample_t adpcm_next;

	always_comb begin
		psg_l_next = reduce(psg.left, PSG_TAIL_SHIFT, boost);
		psg_r_next = reduce(psg.right, PSG_TAIL_SHIFT, boost);
		adpcm_next = reduce(adpcm, ADPCM_TAIL_SHIFT, boost);
	end

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	// CD audio passes through untouched, one cycle late like the others
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			psg_red   <= '0;
			adpcm_red <= '0;
			cdda_q    <= '0;
		end else begin
			psg_red.left  <= psg_l_next;
			psg_red.right <= psg_r_next;
			adpcm_red     <= adpcm_next;
			cdda_q        <= cdda;
		end
	end

endmodule

//--- hw/stereo_mixer.sv
`timescale 1ns/1ps

module stereo_mixer
	import pce_audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,

	input  stereo_sample_t cdda_q,
	input  stereo_sample_t psg_red,
	input  sample_t        adpcm_red,

	output stereo_mix_t    mixed
);

	// Sign extension of one voice into the mixing width
	function automatic mix_t widen(input sample_t x);
		return {{(MIX_W-SAMPLE_W){x[SAMPLE_W-1]}}, x};
	endfunction

	//////////////////////////////////////////////////
	// Pre-sum, first cycle
	//////////////////////////////////////////////////

	stereo_mix_t pre_sum;
	mix_t        adpcm_wide;
	mix_t        pre_l_next;
	mix_t        pre_r_next;

	// ADPCM is mono and goes to both sides
	always_comb begin
		adpcm_wide = widen(adpcm_red);
		pre_l_next = widen(cdda_q.left) + widen(psg_red.left) + adpcm_wide;
		pre_r_next = widen(cdda_q.right) + widen(psg_red.right) + adpcm_wide;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_sum <= '0;
		end else begin
			pre_sum.left  <= pre_l_next;
			pre_sum.right <= pre_r_next;
		end
	end

	//////////////////////////////////////////////////
	// Headroom scale, second cycle
	//////////////////////////////////////////////////

	mix_t head_l_next;
	mix_t head_r_next;

	// Add a quarter so that bits 17:2 span the full 16-bit range
	always_comb begin
		head_l_next = pre_sum.left + (pre_sum.left >>> 2);
		head_r_next = pre_sum.right + (pre_sum.right >>> 2);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mixed <= '0;
		end else begin
			mixed.left  <= head_l_next;
			mixed.right <= head_r_next;
		end
	end

endmodule

//--- hw/dynamic_compressor.sv
`timescale 1ns/1ps

module dynamic_compressor
	import pce_audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,

	input  comp_mode_t     comp_mode,
	input  stereo_mix_t    mixed,

	output stereo_sample_t audio
);

	//////////////////////////////////////////////////
	// Two-slope magnitude curve
	//////////////////////////////////////////////////

	// Works on the magnitude and puts the sign back at the end
	function automatic sample_t compress(
		input sample_t s,
		input logic    heavy
	);
		logic [SAMPLE_W-1:0] mag;
		logic [SAMPLE_W-1:0] light_v;
		logic [SAMPLE_W-1:0] heavy_v;
		logic [SAMPLE_W-1:0] res;

		mag = s[SAMPLE_W-1] ? (~s + 16'd1) : s;

		// Steep slope below the knee
		if (mag < COMP_LIGHT_X) begin
			light_v = mag * COMP_LIGHT_A;
		end else begin
			light_v = (mag - COMP_LIGHT_X) / COMP_LIGHT_F + COMP_LIGHT_B;
		end

		if (mag < COMP_HEAVY_X) begin
			heavy_v = mag * COMP_HEAVY_A;
		end else begin
			heavy_v = (mag - COMP_HEAVY_X) / COMP_HEAVY_F + COMP_HEAVY_B;
		end

		res = heavy ? heavy_v : light_v;

		return s[SAMPLE_W-1] ? (~res + 16'd1) : res;
	endfunction

	//////////////////////////////////////////////////
	// Plain and compressed values
	//////////////////////////////////////////////////

	sample_t plain_l;
	sample_t plain_r;
	sample_t comp_l;
	sample_t comp_r;
	logic    comp_on;
	logic    comp_heavy;

	// Top 16 bits of the headroom-scaled sum
	always_comb begin
		plain_l    = mixed.left[MIX_W-1:MIX_W-SAMPLE_W];
		plain_r    = mixed.right[MIX_W-1:MIX_W-SAMPLE_W];
		comp_on    = comp_mode != 2'd0;
		comp_heavy = comp_mode[1];
		comp_l     = compress(plain_l, comp_heavy);
		comp_r     = compress(plain_r, comp_heavy);
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Both paths go through this register, same latency either way
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio <= '0;
		end else if (comp_on) begin
			audio.left  <= comp_l;
			audio.right <= comp_r;
		end else begin
			audio.left  <= plain_l;
			audio.right <= plain_r;
		end
	end

endmodule

//--- hw/pce_audio_top.sv
`timescale 1ns/1ps

module pce_audio_top
	import pce_audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,

	input  stereo_sample_t cdda,
	input  stereo_sample_t psg,
	input  sample_t        adpcm,
	input  boost_t         boost,
	input  comp_mode_t     comp_mode,

	output stereo_sample_t audio
);

	// Attenuator to mixer
	stereo_sample_t psg_red;
	sample_t        adpcm_red;
	stereo_sample_t cdda_q;

	// Mixer to compressor
	stereo_mix_t    mixed;

	//////////////////////////////////////////////////
	// Pipeline, 1 + 2 + 1 cycles
	//////////////////////////////////////////////////

	voice_attenuator u_attenuator (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.boost     (boost),
		.psg       (psg),
		.adpcm     (adpcm),
		.cdda      (cdda),
		.psg_red   (psg_red),
		.adpcm_red (adpcm_red),
		.cdda_q    (cdda_q)
	);

	stereo_mixer u_mixer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cdda_q    (cdda_q),
		.psg_red   (psg_red),
		.adpcm_red (adpcm_red),
		.mixed     (mixed)
	);

	dynamic_compressor u_compressor (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.comp_mode (comp_mode),
		.mixed     (mixed),
		.audio     (audio)
	);

endmodule

//--- tb/pce_audio_checker.sv
`timescale 1ns/1ps

module pce_audio_checker
	import pce_audio_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,

	// DUT ports, watched only
	input  stereo_sample_t cdda,
	input  stereo_sample_t psg,
	input  sample_t        adpcm,
	input  boost_t         boost,
	input  comp_mode_t     comp_mode,
	input  stereo_sample_t audio,

	// Test bookkeeping from the testbench, name up to 32 characters
	input  int             test_idx,
	input  logic [255:0]   test_name,
	input  logic           check_en,

	output logic           checking,
	output int             tests_done,
	output int             tests_passed,
	output int             tests_failed
);

	// One set of inputs as the DUT saw it on an edge
	typedef struct packed {
		stereo_sample_t cdda;
		stereo_sample_t psg;
		sample_t        adpcm;
		boost_t         boost;
		comp_mode_t     mode;
	} hist_entry_t;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic sample_t reduce_ref(input sample_t x, input int tail, input boost_t b);
		int      xi;
		int      total;
		sample_t wrapped;

		xi      = int'(x);
		total   = (xi >>> 1) + (b[0] ? (xi >>> 1) : (xi >>> 2)) + (xi >>> tail);
		wrapped = total[15:0];
		if (b != 2'd0) begin
			wrapped = wrapped >>> 1;
		end
		return wrapped;
	endfunction

	// Pre-sum plus a quarter, top 16 of 18 bits
	function automatic sample_t mix_ref(input sample_t cd, input sample_t p, input sample_t a);
		int                 pre;
		int                 head;
		logic signed [17:0] pre18;
		logic signed [17:0] head18;

		pre    = int'(cd) + int'(p) + int'(a);
		pre18  = pre[17:0];
		head   = int'(pre18) + (int'(pre18) >>> 2);
		head18 = head[17:0];
		return head18[17:2];
	endfunction

	function automatic sample_t compress_ref(input sample_t s, input logic heavy);
		int si;
		int v;
		int knee;
		int slope;
		int div;
		int offs;
		int r;

		si    = int'(s);
		v     = (si < 0) ? -si : si;
		knee  = heavy ? int'(COMP_HEAVY_X) : int'(COMP_LIGHT_X);
		slope = heavy ? int'(COMP_HEAVY_A) : int'(COMP_LIGHT_A);
		div   = heavy ? int'(COMP_HEAVY_F) : int'(COMP_LIGHT_F);
		offs  = heavy ? int'(COMP_HEAVY_B) : int'(COMP_LIGHT_B);
		if (v < knee) begin
			r = v * slope;
		end else begin
			r = (v - knee) / div + offs;
		end
		r = r & 32'h0000_ffff;
		if (si < 0) begin
			r = (-r) & 32'h0000_ffff;
		end
		return r[15:0];
	endfunction

	// Boost from the sampling edge, comp_mode from the compressor edge
	function automatic stereo_sample_t expected_audio(input hist_entry_t e, input comp_mode_t mode);
		sample_t        adpcm_r;
		sample_t        l;
		sample_t        r;
		stereo_sample_t result;

		adpcm_r = reduce_ref(e.adpcm, ADPCM_TAIL_SHIFT, e.boost);
		l = mix_ref(e.cdda.left, reduce_ref(e.psg.left, PSG_TAIL_SHIFT, e.boost), adpcm_r);
		r = mix_ref(e.cdda.right, reduce_ref(e.psg.right, PSG_TAIL_SHIFT, e.boost), adpcm_r);
		if (mode == 2'd0) begin
			result.left  = l;
			result.right = r;
		end else begin
			result.left  = compress_ref(l, mode[1]);
			result.right = compress_ref(r, mode[1]);
		end
		return result;
	endfunction

	//////////////////////////////////////////////////
	// History and comparison
	//////////////////////////////////////////////////

	hist_entry_t hist [PIPE_LATENCY];
	logic        seen_reset = 1'b0;
	logic        en_prev    = 1'b0;
	boost_t      boost_prev = 2'd0;
	comp_mode_t  mode_prev  = 2'd0;
	int          valid_cnt  = 0;
	int          checks     = 0;
	int          errors     = 0;
	int          done_cnt   = 0;
	int          pass_cnt   = 0;
	int          fail_cnt   = 0;

	always @(posedge clk_sys) begin : monitor
		stereo_sample_t exp_audio;
		hist_entry_t    now_entry;
		int             i;

		// Oldest entry went in PIPE_LATENCY edges ago
		exp_audio = expected_audio(hist[PIPE_LATENCY-1], hist[0].mode);
		if (seen_reset && check_en && valid_cnt >= PIPE_LATENCY) begin
			checks++;
			if (audio !== exp_audio) begin
				errors++;
				if (errors <= 8) begin
					$display("MISMATCH test %0s: expected left %0d right %0d, actual left %0d right %0d",
						test_name, exp_audio.left, exp_audio.right, audio.left, audio.right);
				end
			end
		end

		// Falling check enable closes the test
		if (en_prev && !check_en) begin
			if (checks == 0) begin
				$display("FAIL test %0d %0s: no output was ever compared", test_idx, test_name);
				fail_cnt++;
			end else if (errors != 0) begin
				$display("FAIL test %0d %0s: %0d of %0d outputs wrong",
					test_idx, test_name, errors, checks);
				fail_cnt++;
			end else begin
				$display("PASS test %0d %0s: %0d outputs compared", test_idx, test_name, checks);
				pass_cnt++;
			end
			done_cnt++;
			checks = 0;
			errors = 0;
		end

		now_entry.cdda  = cdda;
		now_entry.psg   = psg;
		now_entry.adpcm = adpcm;
		now_entry.boost = boost;
		now_entry.mode  = comp_mode;

		// Reset empties the pipeline, same as zero samples
		if (reset) begin
			for (i = 0; i < PIPE_LATENCY; i++) begin
				hist[i] = '0;
			end
			seen_reset = 1'b1;
			valid_cnt  = PIPE_LATENCY;
		end else begin
			for (i = PIPE_LATENCY - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = now_entry;
			if (boost != boost_prev || comp_mode != mode_prev) begin
				valid_cnt = 0;
			end else if (valid_cnt < PIPE_LATENCY) begin
				valid_cnt++;
			end
		end
		boost_prev = boost;
		mode_prev  = comp_mode;
		en_prev    = check_en;

		checking     <= seen_reset && check_en && valid_cnt >= PIPE_LATENCY;
		tests_done   <= done_cnt;
		tests_passed <= pass_cnt;
		tests_failed <= fail_cnt;
	end

endmodule

//--- tb/pce_audio_tb.sv
`timescale 1ns/1ps

module pce_audio_tb
	import pce_audio_pkg::*;
();

	localparam int START_TIMEOUT = 40;
	localparam int DONE_TIMEOUT  = 40;

	logic           clk_sys;
	logic           reset;
	stereo_sample_t cdda;
	stereo_sample_t psg;
	sample_t        adpcm;
	boost_t         boost;
	comp_mode_t     comp_mode;
	stereo_sample_t audio;

	int             test_idx;
	logic [255:0]   test_name;
	logic           check_en;
	logic           checking;
	int             tests_done;
	int             tests_passed;
	int             tests_failed;

	int             seed;
	logic           timed_out;
	int             b;
	int             m;
	int             idx;

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	pce_audio_top UUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cdda      (cdda),
		.psg       (psg),
		.adpcm     (adpcm),
		.boost     (boost),
		.comp_mode (comp_mode),
		.audio     (audio)
	);

	pce_audio_checker u_checker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cdda         (cdda),
		.psg          (psg),
		.adpcm        (adpcm),
		.boost        (boost),
		.comp_mode    (comp_mode),
		.audio        (audio),
		.test_idx     (test_idx),
		.test_name    (test_name),
		.check_en     (check_en),
		.checking     (checking),
		.tests_done   (tests_done),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed)
	);

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// 0 random, 1 small, 2 large negative, 3 full positive, 4 full negative
	task automatic drive_pattern(input int pattern);
		sample_t v [5];
		int      r;
		int      i;

		for (i = 0; i < 5; i++) begin
			r = $random(seed);
			case (pattern)
				1: r = r % 4096;
				2: r = (r & 8191) - 32768;
				3: r = 32767;
				4: r = -32768;
				default: r = r;
			endcase
			v[i] = r[15:0];
		end
		cdda.left  <= v[0];
		cdda.right <= v[1];
		psg.left   <= v[2];
		psg.right  <= v[3];
		adpcm      <= v[4];
	endtask

	task automatic finish_test(input int test_no);
		int waited;

		@(posedge clk_sys);
		check_en <= 1'b0;
		waited = 0;
		while (tests_done <= test_no && waited < DONE_TIMEOUT) begin
			@(posedge clk_sys);
			waited++;
		end
		if (tests_done <= test_no) begin
			$display("Timeout: the checker never reported test %0d", test_no);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input int test_no, input string name, input boost_t bst,
		input comp_mode_t mode, input int pattern, input int count);
		logic [255:0] name_vec;
		int           waited;
		int           n;

		if (timed_out) begin
			return;
		end
		$sformat(name_vec, "%s", name);
		@(posedge clk_sys);
		test_idx  <= test_no;
		test_name <= name_vec;
		boost     <= bst;
		comp_mode <= mode;
		check_en  <= 1'b1;
		drive_pattern(pattern);

		// Outputs after a configuration change are skipped by the checker
		waited = 0;
		while (!checking && waited < START_TIMEOUT) begin
			@(posedge clk_sys);
			drive_pattern(pattern);
			waited++;
		end
		if (!checking) begin
			$display("Timeout: test %0s did not start comparing within %0d cycles",
				name, START_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			for (n = 0; n < count + PIPE_LATENCY + 1; n++) begin
				@(posedge clk_sys);
				drive_pattern(pattern);
			end
			finish_test(test_no);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		seed      = 32'h8e03_73ac;
		timed_out = 1'b0;
		reset     = 1'b1;
		cdda      = '0;
		psg       = '0;
		adpcm     = '0;
		boost     = 2'd0;
		comp_mode = 2'd0;
		check_en  = 1'b1;
		test_idx  = 0;
		$sformat(test_name, "reset");

		// Inputs move during reset, outputs must stay zero
		repeat (2) begin
			@(posedge clk_sys);
			drive_pattern(0);
		end
		reset <= 1'b0;
		repeat (12) begin
			@(posedge clk_sys);
			drive_pattern(0);
		end
		finish_test(0);

		run_test(1, "bypass_noboost", 2'd0, 2'd0, 0, 200);
		run_test(2, "bypass_boost2x", 2'd1, 2'd0, 0, 200);
		run_test(3, "bypass_boost4x", 2'd2, 2'd0, 0, 200);
		run_test(4, "light_random", 2'd0, 2'd1, 0, 100);
		run_test(5, "light_small", 2'd0, 2'd1, 1, 50);
		run_test(6, "light_large_negative", 2'd0, 2'd1, 2, 50);
		run_test(7, "heavy_mode2", 2'd0, 2'd2, 0, 100);
		run_test(8, "heavy_mode3", 2'd1, 2'd3, 0, 100);

		// Full scale on every voice, all boost and mode pairs
		idx = 9;
		for (b = 0; b < 4; b++) begin
			for (m = 0; m < 4; m++) begin
				run_test(idx, $sformatf("extreme_b%0d_m%0d_pos", b, m), b[1:0], m[1:0], 3, 8);
				run_test(idx + 1, $sformatf("extreme_b%0d_m%0d_neg", b, m), b[1:0], m[1:0], 4, 8);
				idx = idx + 2;
			end
		end

		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (timed_out || tests_failed != 0 || tests_passed == 0) begin
			$display("Something failed");
		end else begin
			$display("Everything OK");
		end
		$finish;
	end

endmodule

//--- pce_audio.f
hw/pce_audio_pkg.sv
hw/voice_attenuator.sv
hw/stereo_mixer.sv
hw/dynamic_compressor.sv
hw/pce_audio_top.sv
tb/pce_audio_checker.sv
tb/pce_audio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module pce_audio_tb \
	-f pce_audio.f \
	-o sim_pce_audio

output="$(./obj_dir/sim_pce_audio)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
